// File: vlog.f
ooo_pkg.sv
ooo_ifs.sv
dispatch_stage.sv
alu_lane.sv
cdb_arbiter.sv
ooo_core.sv
tb_ooo_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core \
  -f vlog.f -o sim_ooo_core

out=$(./obj_dir/sim_ooo_core)
echo "$out"

if echo "$out" | grep -qxF '>>> PASS'; then
  exit 0
fi
exit 1

// File: tb_ooo_core.sv
`timescale 1ns/100ps

module tb_ooo_core
  import ooo_pkg::*;
();

  // Upper bound on operations over all phases, sizes the watchdog
  localparam int MAX_OPS        = 500;
  localparam int WATCHDOG_CYCLES = MAX_OPS * 50 + 1000;

  logic    clk;
  logic    rst;
  logic    i_disp_valid;
  lane_t   i_disp_lane;
  alu_op_e i_disp_op;
  preg_t   i_disp_prs1;
  preg_t   i_disp_prs2;
  preg_t   i_disp_prd;
  data_t   i_disp_imm;
  logic    i_disp_use_imm;
  logic    o_disp_ready;
  logic    i_preload_valid;
  preg_t   i_preload_prd;
  data_t   i_preload_data;
  logic    o_cdb_valid;
  preg_t   o_cdb_prd;
  data_t   o_cdb_data;

  // ====================
  // Reference model state
  // ====================
  data_t  val       [NUM_PREGS];
  int     inflight  [NUM_PREGS];
  int     bcast_cnt [NUM_PREGS];
  logic   written   [NUM_PREGS];
  preg_t  dep1_reg  [NUM_PREGS];
  preg_t  dep2_reg  [NUM_PREGS];
  int     dep1_need [NUM_PREGS];
  int     dep2_need [NUM_PREGS];
  int     pending_cnt;
  int     accepted_ops;
  logic   any_accepted;
  logic   saw_lane2_full;
  int     value_errors;
  int     other_errors;
  integer seed;

  ooo_core i_dut (
    .clk             (clk),
    .rst             (rst),
    .i_disp_valid    (i_disp_valid),
    .i_disp_lane     (i_disp_lane),
    .i_disp_op       (i_disp_op),
    .i_disp_prs1     (i_disp_prs1),
    .i_disp_prs2     (i_disp_prs2),
    .i_disp_prd      (i_disp_prd),
    .i_disp_imm      (i_disp_imm),
    .i_disp_use_imm  (i_disp_use_imm),
    .o_disp_ready    (o_disp_ready),
    .i_preload_valid (i_preload_valid),
    .i_preload_prd   (i_preload_prd),
    .i_preload_data  (i_preload_data),
    .o_cdb_valid     (o_cdb_valid),
    .o_cdb_prd       (o_cdb_prd),
    .o_cdb_data      (o_cdb_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ALU behavior as the operation set defines it
  function automatic data_t alu_ref(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SLT:     return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
      default: return '0;
    endcase
  endfunction

  always @(posedge clk) begin : model_update
    logic  acc;
    logic  hit1;
    logic  hit2;
    int    pend_next;
    data_t op_a;
    data_t op_b;
    if (rst) begin
      for (int r = 0; r < NUM_PREGS; r++) begin
        val[r]       <= '0;
        inflight[r]  <= 0;
        bcast_cnt[r] <= 0;
        written[r]   <= (r == 0);
        dep1_reg[r]  <= '0;
        dep2_reg[r]  <= '0;
        dep1_need[r] <= 0;
        dep2_need[r] <= 0;
      end
      pending_cnt  <= 0;
      accepted_ops <= 0;
      any_accepted <= 1'b0;
    end else begin
      acc       = i_disp_valid && o_disp_ready;
      pend_next = pending_cnt;
      if (o_cdb_valid) begin
        inflight[o_cdb_prd]  <= inflight[o_cdb_prd] - 1;
        bcast_cnt[o_cdb_prd] <= bcast_cnt[o_cdb_prd] + 1;
        pend_next = pend_next - 1;
      end
      if (i_preload_valid) begin
        val[i_preload_prd]     <= i_preload_data;
        written[i_preload_prd] <= 1'b1;
      end
      if (acc) begin
        // A source broadcast at this very edge counts as already produced
        hit1 = o_cdb_valid && (o_cdb_prd == i_disp_prs1);
        hit2 = o_cdb_valid && (o_cdb_prd == i_disp_prs2) && !i_disp_use_imm;
        op_a = val[i_disp_prs1];
        op_b = i_disp_use_imm ? i_disp_imm : val[i_disp_prs2];
        val[i_disp_prd]       <= alu_ref(i_disp_op, op_a, op_b);
        inflight[i_disp_prd]  <= inflight[i_disp_prd] + 1;
        written[i_disp_prd]   <= 1'b1;
        dep1_reg[i_disp_prd]  <= i_disp_prs1;
        dep2_reg[i_disp_prd]  <= i_disp_prs2;
        dep1_need[i_disp_prd] <= (inflight[i_disp_prs1] != 0 && !hit1) ?
                                 bcast_cnt[i_disp_prs1] + 1 : 0;
        dep2_need[i_disp_prd] <= (inflight[i_disp_prs2] != 0 && !hit2 && !i_disp_use_imm) ?
                                 bcast_cnt[i_disp_prs2] + 1 : 0;
        pend_next = pend_next + 1;
        accepted_ops <= accepted_ops + 1;
        any_accepted <= 1'b1;
      end
      pending_cnt <= pend_next;
    end
  end

  // ====================
  // Checks
  // ====================
  a_quiet_until_accept: assert property (@(posedge clk) disable iff (rst)
    !any_accepted |-> !o_cdb_valid)
    else begin
      other_errors = other_errors + 1;
      $display("bus broadcast at %0t before any operation was accepted", $time);
    end

  a_ready_after_reset: assert property (@(posedge clk) disable iff (rst)
    !any_accepted && int'(i_disp_lane) < NUM_LANES |-> o_disp_ready)
    else begin
      other_errors = other_errors + 1;
      $display("mismatch at %0t: o_disp_ready expected 1 got 0", $time);
    end

  a_bad_lane_blocked: assert property (@(posedge clk) disable iff (rst)
    int'(i_disp_lane) >= NUM_LANES |-> !o_disp_ready)
    else begin
      other_errors = other_errors + 1;
      $display("mismatch at %0t: o_disp_ready expected 0 got 1", $time);
    end

  a_bcast_pending: assert property (@(posedge clk) disable iff (rst)
    o_cdb_valid |-> inflight[o_cdb_prd] > 0)
    else begin
      other_errors = other_errors + 1;
      $display("broadcast of register %0d at %0t which is not pending",
               $sampled(o_cdb_prd), $time);
    end

  a_bcast_value: assert property (@(posedge clk) disable iff (rst)
    o_cdb_valid |-> o_cdb_data == val[o_cdb_prd])
    else begin
      value_errors = value_errors + 1;
      $display("mismatch at %0t: o_cdb_data for register %0d expected %h got %h", $time,
               $sampled(o_cdb_prd), val[$sampled(o_cdb_prd)], $sampled(o_cdb_data));
    end

  a_bcast_order: assert property (@(posedge clk) disable iff (rst)
    o_cdb_valid |-> bcast_cnt[dep1_reg[o_cdb_prd]] >= dep1_need[o_cdb_prd] &&
                    bcast_cnt[dep2_reg[o_cdb_prd]] >= dep2_need[o_cdb_prd])
    else begin
      other_errors = other_errors + 1;
      $display("register %0d broadcast at %0t before its producer", $sampled(o_cdb_prd), $time);
    end

  // ====================
  // Stimulus helpers
  // ====================
  function automatic preg_t preloaded_reg();
    return preg_t'(1 + $unsigned($random(seed)) % 31);
  endfunction

  function automatic preg_t free_dest(input int lo, input int hi);
    preg_t r;
    do begin
      r = preg_t'(lo + $unsigned($random(seed)) % (hi - lo + 1));
    end while (inflight[r] != 0);
    return r;
  endfunction

  function automatic preg_t known_src();
    preg_t r;
    do begin
      r = preg_t'($random(seed));
    end while (!written[r]);
    return r;
  endfunction

  // Called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic dispatch_op(input lane_t lane, input alu_op_e op, input preg_t rs1,
                             input preg_t rs2, input preg_t rd, input data_t imm,
                             input logic use_imm);
    i_disp_valid   = 1'b1;
    i_disp_lane    = lane;
    i_disp_op      = op;
    i_disp_prs1    = rs1;
    i_disp_prs2    = rs2;
    i_disp_prd     = rd;
    i_disp_imm     = imm;
    i_disp_use_imm = use_imm;
    #1;
    while (!o_disp_ready) begin
      if (lane == 2'd2) begin
        saw_lane2_full = 1'b1;
      end
      @(posedge clk);
      #3;
    end
    @(posedge clk);
    #2;
    i_disp_valid = 1'b0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_bcast(input preg_t p);
    while (!(o_cdb_valid && o_cdb_prd == p)) begin
      next_cycle();
    end
  endtask

  task automatic wait_drain();
    while (pending_cnt != 0) begin
      next_cycle();
    end
  endtask

  // Consumers before, during and after the producer's broadcast
  task automatic chain_case(input lane_t la, input lane_t lb, input lane_t lc);
    preg_t p;
    preg_t c1;
    preg_t c2;
    preg_t c3;
    p = free_dest(32, 127);
    dispatch_op(la, ADD, preloaded_reg(), preloaded_reg(), p, '0, 1'b0);
    c1 = free_dest(32, 127);
    dispatch_op(lb, SUB, p, preloaded_reg(), c1, '0, 1'b0);
    wait_bcast(p);
    c2 = free_dest(32, 127);
    dispatch_op(lc, XOR, p, c1, c2, '0, 1'b0);
    repeat (3) next_cycle();
    c3 = free_dest(32, 127);
    dispatch_op(la, SLL, p, '0, c3, data_t'(3), 1'b1);
    wait_drain();
  endtask

  task automatic show_counts();
    $display("summary: %0d ops accepted, %0d value errors, %0d other errors",
             accepted_ops, value_errors, other_errors);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d destinations pending",
             WATCHDOG_CYCLES, pending_cnt);
    show_counts();
    $display(">>> FAIL");
    $finish;
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    preg_t prev2;
    preg_t rd;
    int    n;
    seed            = 32'hf4fc;
    value_errors    = 0;
    other_errors    = 0;
    saw_lane2_full  = 1'b0;
    rst             = 1'b1;
    i_disp_valid    = 1'b0;
    i_disp_lane     = '0;
    i_disp_op       = ADD;
    i_disp_prs1     = '0;
    i_disp_prs2     = '0;
    i_disp_prd      = '0;
    i_disp_imm      = '0;
    i_disp_use_imm  = 1'b0;
    i_preload_valid = 1'b0;
    i_preload_prd   = '0;
    i_preload_data  = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    // Idle ready sweep, then preload with the bus quiet
    for (int l = 0; l < 4; l++) begin
      i_disp_lane = lane_t'(l);
      next_cycle();
    end
    i_disp_lane = '0;
    for (int r = 1; r < 32; r++) begin
      i_preload_valid = 1'b1;
      i_preload_prd   = preg_t'(r);
      i_preload_data  = data_t'($random(seed));
      next_cycle();
    end
    i_preload_valid = 1'b0;
    repeat (4) next_cycle();

    // Every operation, with and without immediate, spread over the lanes
    for (int k = 0; k < 16; k++) begin
      rd = free_dest(32, 127);
      dispatch_op(lane_t'(k % 3), alu_op_e'(k % 8), preloaded_reg(), preloaded_reg(), rd,
                  data_t'($random(seed)), k >= 8);
    end
    wait_drain();

    chain_case(2'd0, 2'd1, 2'd2);
    chain_case(2'd1, 2'd2, 2'd0);
    chain_case(2'd2, 2'd0, 2'd1);

    // Lane 2 carries a dependency chain until its station backs up
    prev2 = preloaded_reg();
    n     = 0;
    while (!saw_lane2_full && n < 150) begin
      rd = free_dest(32, 127);
      if (n % 5 == 0) begin
        dispatch_op(2'd0, ADD, preloaded_reg(), preloaded_reg(), rd, '0, 1'b0);
      end else if (n % 5 == 2) begin
        dispatch_op(2'd1, OR, preloaded_reg(), preloaded_reg(), rd, '0, 1'b0);
      end else begin
        dispatch_op(2'd2, XOR, prev2, preloaded_reg(), rd, '0, 1'b0);
        prev2 = rd;
      end
      n++;
    end
    wait_drain();
    assert (saw_lane2_full)
      else begin
        other_errors = other_errors + 1;
        $display("lane 2 never showed back-pressure");
      end

    // Random mix with dependencies through any written register
    for (int i = 0; i < 300; i++) begin
      rd = free_dest(1, 127);
      dispatch_op(lane_t'($unsigned($random(seed)) % 3), alu_op_e'($unsigned($random(seed)) % 8),
                  known_src(), known_src(), rd, data_t'($random(seed)), $random(seed) & 1);
      if (($random(seed) & 7) == 0) begin
        next_cycle();
      end
    end
    wait_drain();
    repeat (4) next_cycle();

    show_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: ooo_core.sv
`timescale 1ns/100ps

module ooo_core
  import ooo_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  // Renamed operations
  input  logic    i_disp_valid,
  input  lane_t   i_disp_lane,
  input  alu_op_e i_disp_op,
  input  preg_t   i_disp_prs1,
  input  preg_t   i_disp_prs2,
  input  preg_t   i_disp_prd,
  input  data_t   i_disp_imm,
  input  logic    i_disp_use_imm,
  output logic    o_disp_ready,

  // Register file initialization
  input  logic    i_preload_valid,
  input  preg_t   i_preload_prd,
  input  data_t   i_preload_data,

  // Common data bus
  output logic    o_cdb_valid,
  output preg_t   o_cdb_prd,
  output data_t   o_cdb_data
);

  issue_if iss [NUM_LANES] ();
  cdb_if   cdb (.clk(clk), .rst(rst));

  // ====================
  // Dispatch
  // ====================
  dispatch_stage dispatch_inst (
    .clk             (clk),
    .rst             (rst),
    .i_disp_valid    (i_disp_valid),
    .i_disp_lane     (i_disp_lane),
    .i_disp_op       (i_disp_op),
    .i_disp_prs1     (i_disp_prs1),
    .i_disp_prs2     (i_disp_prs2),
    .i_disp_prd      (i_disp_prd),
    .i_disp_imm      (i_disp_imm),
    .i_disp_use_imm  (i_disp_use_imm),
    .o_disp_ready    (o_disp_ready),
    .i_preload_valid (i_preload_valid),
    .i_preload_prd   (i_preload_prd),
    .i_preload_data  (i_preload_data),
    .iss             (iss),
    .cdb             (cdb)
  );

  // ====================
  // ALU lanes
  // ====================
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    alu_lane #(
      .LANE_IDX (g)
    ) lane_inst (
      .clk (clk),
      .rst (rst),
      .iss (iss[g]),
      .cdb (cdb)
    );
  end

  cdb_arbiter arbiter_inst (
    .cdb (cdb)
  );

  assign o_cdb_valid = cdb.valid;
  assign o_cdb_prd   = cdb.prd;
  assign o_cdb_data  = cdb.data;

endmodule

// File: cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter
  import ooo_pkg::*;
(
  cdb_if.arb cdb
);

  logic [NUM_LANES-1:0] req_vec;
  logic [NUM_LANES-1:0] grant_vec;
  lane_t                winner;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign req_vec[g]   = cdb.req[g];
    assign cdb.grant[g] = grant_vec[g];
  end

  // Fixed priority, lane 0 first
  always_comb begin
    grant_vec = '0;
    winner    = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (req_vec[i]) begin
        grant_vec    = '0;
        grant_vec[i] = 1'b1;
        winner       = lane_t'(i);
      end
    end
  end

  assign cdb.valid = |req_vec;
  assign cdb.prd   = cdb.req_prd[winner];
  assign cdb.data  = cdb.req_data[winner];

  // One grant, only to a requester, and the bus is busy exactly when granted
  a_one_grant: assert property (@(posedge cdb.clk) disable iff (cdb.rst)
    $onehot0(grant_vec) && ((grant_vec & ~req_vec) == '0) &&
      (cdb.valid == (grant_vec != '0)))
    else $error("bad bus grant %b for requests %b", grant_vec, req_vec);

endmodule

// File: alu_lane.sv
`timescale 1ns/100ps

module alu_lane
  import ooo_pkg::*;
#(
  parameter int unsigned LANE_IDX = 0
)(
  input logic   clk,
  input logic   rst,
  issue_if.lane iss,
  cdb_if.lane   cdb
);

  // ====================
  // Station entries
  // ====================
  logic [RS_DEPTH-1:0] ent_valid;
  alu_op_e             ent_op    [RS_DEPTH];
  preg_t               ent_prd   [RS_DEPTH];
  preg_t               ent_tag1  [RS_DEPTH];
  preg_t               ent_tag2  [RS_DEPTH];
  logic [RS_DEPTH-1:0] ent_rdy1;
  logic [RS_DEPTH-1:0] ent_rdy2;
  data_t               ent_data1 [RS_DEPTH];
  data_t               ent_data2 [RS_DEPTH];

  logic [RS_IDX_W-1:0] free_idx;
  logic [RS_IDX_W-1:0] issue_idx;
  logic                issue_any;
  logic                issue_fire;

  data_t op_a;
  data_t op_b;
  data_t alu_result;

  // Result register waiting for the bus
  logic  res_valid;
  preg_t res_prd;
  data_t res_data;

  assign iss.full = &ent_valid;

  // Lowest free slot and lowest entry with both sources ready
  always_comb begin
    free_idx  = '0;
    issue_idx = '0;
    issue_any = 1'b0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx = RS_IDX_W'(i);
      end
      if (ent_valid[i] && ent_rdy1[i] && ent_rdy2[i]) begin
        issue_idx = RS_IDX_W'(i);
        issue_any = 1'b1;
      end
    end
  end

  // Issue only when the result register frees up this edge
  assign issue_fire = issue_any && (!res_valid || cdb.grant[LANE_IDX]);

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (issue_fire && issue_idx == RS_IDX_W'(i)) begin
          ent_valid[i] <= 1'b0;
        end
        if (iss.alloc && free_idx == RS_IDX_W'(i)) begin
          ent_valid[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      // Wakeup from the bus
      if (cdb.valid && !ent_rdy1[i] && ent_tag1[i] == cdb.prd) begin
        ent_rdy1[i]  <= 1'b1;
        ent_data1[i] <= cdb.data;
      end
      if (cdb.valid && !ent_rdy2[i] && ent_tag2[i] == cdb.prd) begin
        ent_rdy2[i]  <= 1'b1;
        ent_data2[i] <= cdb.data;
      end
      if (iss.alloc && free_idx == RS_IDX_W'(i)) begin
        ent_op[i]    <= iss.op;
        ent_prd[i]   <= iss.prd;
        ent_tag1[i]  <= iss.src1_tag;
        ent_rdy1[i]  <= iss.src1_ready;
        ent_data1[i] <= iss.src1_data;
        ent_tag2[i]  <= iss.src2_tag;
        ent_rdy2[i]  <= iss.src2_ready;
        ent_data2[i] <= iss.src2_data;
      end
    end
  end

  // ====================
  // ALU
  // ====================
  always_comb begin
    op_a = ent_data1[issue_idx];
    op_b = ent_data2[issue_idx];
    case (ent_op[issue_idx])
      ADD:     alu_result = op_a + op_b;
      SUB:     alu_result = op_a - op_b;
      AND:     alu_result = op_a & op_b;
      OR:      alu_result = op_a | op_b;
      XOR:     alu_result = op_a ^ op_b;
      SLL:     alu_result = op_a << op_b[4:0];
      SRL:     alu_result = op_a >> op_b[4:0];
      SLT:     alu_result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (issue_fire) begin
      res_valid <= 1'b1;
    end else if (cdb.grant[LANE_IDX]) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      res_prd  <= ent_prd[issue_idx];
      res_data <= alu_result;
    end
  end

  assign cdb.req[LANE_IDX]      = res_valid;
  assign cdb.req_prd[LANE_IDX]  = res_prd;
  assign cdb.req_data[LANE_IDX] = res_data;

  a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
    iss.alloc |-> !iss.full)
    else $error("lane %0d allocated while full", LANE_IDX);

  // A losing request keeps its destination and value until granted
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    res_valid && !cdb.grant[LANE_IDX] |=>
      res_valid && $stable(res_prd) && $stable(res_data))
    else $error("lane %0d dropped or changed a pending request", LANE_IDX);

endmodule

// File: dispatch_stage.sv
`timescale 1ns/100ps

module dispatch_stage
  import ooo_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  input  logic    i_disp_valid,
  input  lane_t   i_disp_lane,
  input  alu_op_e i_disp_op,
  input  preg_t   i_disp_prs1,
  input  preg_t   i_disp_prs2,
  input  preg_t   i_disp_prd,
  input  data_t   i_disp_imm,
  input  logic    i_disp_use_imm,
  output logic    o_disp_ready,

  input  logic    i_preload_valid,
  input  preg_t   i_preload_prd,
  input  data_t   i_preload_data,

  issue_if.dispatch iss [NUM_LANES],
  cdb_if.listen     cdb
);

  // ====================
  // Register file and ready table
  // ====================
  data_t                prf [NUM_PREGS];
  logic [NUM_PREGS-1:0] preg_ready;

  // Lanes beyond NUM_LANES read as permanently full
  logic [(1 << LANE_W)-1:0] lane_full;
  logic                     accept;

  preg_t src1_tag;
  logic  src1_hit;
  logic  src1_ready;
  data_t src1_data;
  preg_t src2_tag;
  logic  src2_hit;
  logic  src2_ready;
  data_t src2_data;

  assign o_disp_ready = !lane_full[i_disp_lane];
  assign accept       = i_disp_valid && o_disp_ready;

  always_ff @(posedge clk) begin
    if (cdb.valid) begin
      prf[cdb.prd] <= cdb.data;
    end
    if (i_preload_valid) begin
      prf[i_preload_prd] <= i_preload_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      preg_ready <= '1;
    end else begin
      if (accept && i_disp_prd != '0) begin
        preg_ready[i_disp_prd] <= 1'b0;
      end
      // Producer results and preloads make the register readable again
      if (cdb.valid) begin
        preg_ready[cdb.prd] <= 1'b1;
      end
      if (i_preload_valid) begin
        preg_ready[i_preload_prd] <= 1'b1;
      end
    end
  end

  // ====================
  // Operand read with bus bypass
  // ====================
  always_comb begin
    src1_tag   = i_disp_prs1;
    src1_hit   = cdb.valid && (cdb.prd == src1_tag);
    src1_ready = (src1_tag == '0) || preg_ready[src1_tag] || src1_hit;
    if (src1_tag == '0) begin
      src1_data = '0;
    end else if (src1_hit) begin
      src1_data = cdb.data;
    end else begin
      src1_data = prf[src1_tag];
    end
  end

  always_comb begin
    // Immediate takes the place of source 2 and waits on nothing
    src2_tag   = i_disp_use_imm ? '0 : i_disp_prs2;
    src2_hit   = cdb.valid && (cdb.prd == src2_tag);
    src2_ready = (src2_tag == '0) || preg_ready[src2_tag] || src2_hit;
    if (i_disp_use_imm) begin
      src2_data = i_disp_imm;
    end else if (src2_tag == '0) begin
      src2_data = '0;
    end else if (src2_hit) begin
      src2_data = cdb.data;
    end else begin
      src2_data = prf[src2_tag];
    end
  end

  // ====================
  // Steering to lanes
  // ====================
  for (genvar g = 0; g < (1 << LANE_W); g++) begin : g_lane
    if (g < NUM_LANES) begin : g_real
      assign lane_full[g]    = iss[g].full;
      assign iss[g].alloc      = accept && (i_disp_lane == lane_t'(g));
      assign iss[g].op         = i_disp_op;
      assign iss[g].prd        = i_disp_prd;
      assign iss[g].src1_tag   = src1_tag;
      assign iss[g].src1_ready = src1_ready;
      assign iss[g].src1_data  = src1_data;
      assign iss[g].src2_tag   = src2_tag;
      assign iss[g].src2_ready = src2_ready;
      assign iss[g].src2_data  = src2_data;
    end else begin : g_none
      assign lane_full[g] = 1'b1;
    end
  end

  // Register 0 is never a write target, from the bus or from preload
  a_no_write_r0: assert property (@(posedge clk) disable iff (rst)
    (cdb.valid |-> cdb.prd != '0) and (i_preload_valid |-> i_preload_prd != '0))
    else $error("write to physical register 0");

  // Rename must hand out only free destinations
  a_dest_free: assert property (@(posedge clk) disable iff (rst)
    accept && i_disp_prd != '0 |-> preg_ready[i_disp_prd])
    else $error("destination %0d accepted while still pending", i_disp_prd);

endmodule

// File: ooo_ifs.sv
`timescale 1ns/100ps

// Dispatch stage to one ALU lane, operands travel as values
interface issue_if
  import ooo_pkg::*;
();

  logic    alloc;
  alu_op_e op;
  preg_t   prd;

  preg_t   src1_tag;
  logic    src1_ready;
  data_t   src1_data;
  preg_t   src2_tag;
  logic    src2_ready;
  data_t   src2_data;

  // Station has no free entry
  logic    full;

  modport dispatch (
    output alloc, op, prd,
    output src1_tag, src1_ready, src1_data,
    output src2_tag, src2_ready, src2_data,
    input  full
  );

  modport lane (
    input  alloc, op, prd,
    input  src1_tag, src1_ready, src1_data,
    input  src2_tag, src2_ready, src2_data,
    output full
  );

endinterface

// Common data bus with one request/grant pair per lane
interface cdb_if
  import ooo_pkg::*;
(
  input logic clk,
  input logic rst
);

  logic  valid;
  preg_t prd;
  data_t data;

  logic  req      [NUM_LANES];
  preg_t req_prd  [NUM_LANES];
  data_t req_data [NUM_LANES];
  logic  grant    [NUM_LANES];

  modport arb (
    input  clk, rst,
    input  req, req_prd, req_data,
    output grant, valid, prd, data
  );

  modport lane (
    input  valid, prd, data, grant,
    output req, req_prd, req_data
  );

  modport listen (
    input valid, prd, data
  );

endinterface

// File: ooo_pkg.sv
package ooo_pkg;

  // ====================
  // Widths and sizes
  // ====================
  localparam int DATA_W    = 32;
  localparam int PREG_W    = 7;
  localparam int NUM_PREGS = 1 << PREG_W;
  localparam int NUM_LANES = 3;
  localparam int LANE_W    = 2;
  localparam int RS_DEPTH  = 4;
  localparam int RS_IDX_W  = $clog2(RS_DEPTH);

  // ====================
  // Shared types
  // ====================

  // Operand or result word
  typedef logic [DATA_W-1:0] data_t;

  // Physical register number, register 0 is hardwired to zero
  typedef logic [PREG_W-1:0] preg_t;

  // Lane index, wide enough to also name lanes that do not exist
  typedef logic [LANE_W-1:0] lane_t;

  // ALU operations
  // Shifts take the low 5 bits of operand b, SLT is a signed compare
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    SLT = 3'd7
  } alu_op_e;

endpackage
